// ==== hw/mem_pkg.sv ====
// Fixed 256-bit line of eight 32-bit words; OFFSET_BITS must equal log2(LINE_BITS/8)
package mem_pkg;

  // Line and word geometry
  localparam int LINE_BITS      = 256;
  localparam int WORD_BITS      = 32;
  localparam int WORDS_PER_LINE = LINE_BITS / WORD_BITS;

  // Byte offset inside one line
  localparam int OFFSET_BITS = 5;

  // CPU byte address
  localparam int ADDR_BITS = 32;

  // Owner of the shared line memory port
  typedef enum logic [1:0] {
    LOCK_FREE,
    LOCK_INSTR,
    LOCK_DATA
  } lock_e;

endpackage

// ==== hw/line_arbiter.sv ====
// One owner at a time; instruction side wins a tie from FREE, and each owner holds its request until ready or done
module line_arbiter (
  input  logic                          i_clock,
  input  logic                          i_rst,
  // Instruction cache
  input  logic [mem_pkg::ADDR_BITS-1:0] i_ic_address,
  input  logic                          i_ic_read,
  output logic [mem_pkg::LINE_BITS-1:0] o_ic_rdata,
  output logic                          o_ic_ready,
  // Data cache
  input  logic [mem_pkg::ADDR_BITS-1:0] i_dc_address,
  input  logic                          i_dc_read,
  input  logic                          i_dc_write,
  input  logic [mem_pkg::LINE_BITS-1:0] i_dc_wdata,
  output logic [mem_pkg::LINE_BITS-1:0] o_dc_rdata,
  output logic                          o_dc_ready,
  output logic                          o_dc_done,
  // Line memory
  output logic [mem_pkg::ADDR_BITS-1:0] o_mem_address,
  output logic                          o_mem_read,
  output logic                          o_mem_write,
  output logic [mem_pkg::LINE_BITS-1:0] o_mem_wdata,
  input  logic [mem_pkg::LINE_BITS-1:0] i_mem_rdata,
  input  logic                          i_mem_ready,
  input  logic                          i_mem_done
);

  mem_pkg::lock_e lock_q;
  logic           instr_owner;
  logic           data_owner;

  assign instr_owner = (lock_q == mem_pkg::LOCK_INSTR);
  assign data_owner  = (lock_q == mem_pkg::LOCK_DATA);

  // Owner's request goes straight to memory
  assign o_mem_address = data_owner  ? i_dc_address :
                         instr_owner ? i_ic_address : '0;
  assign o_mem_read    = (instr_owner && i_ic_read) || (data_owner && i_dc_read);
  assign o_mem_write   = data_owner && i_dc_write;
  assign o_mem_wdata   = data_owner ? i_dc_wdata : '0;

  // Responses only reach the owner
  assign o_ic_rdata = instr_owner ? i_mem_rdata : '0;
  assign o_ic_ready = instr_owner && i_mem_ready;
  assign o_dc_rdata = data_owner ? i_mem_rdata : '0;
  assign o_dc_ready = data_owner && i_mem_ready;
  assign o_dc_done  = data_owner && i_mem_done;

  always_ff @(posedge i_clock) begin
    if (i_rst) begin
      lock_q <= mem_pkg::LOCK_FREE;
    end else begin
      case (lock_q)
        mem_pkg::LOCK_FREE: begin
          if (i_ic_read) begin
            lock_q <= mem_pkg::LOCK_INSTR;
          end else if (i_dc_read || i_dc_write) begin
            lock_q <= mem_pkg::LOCK_DATA;
          end
        end
        default: begin
          // Released once the transfer completes
          if (i_mem_ready || i_mem_done) begin
            lock_q <= mem_pkg::LOCK_FREE;
          end
        end
      endcase
    end
  end

  a_single_strobe: assert property (@(posedge i_clock) disable iff (i_rst)
    !(o_mem_read && o_mem_write));

  // Memory only answers a request made under a lock
  a_no_orphan_pulse: assert property (@(posedge i_clock) disable iff (i_rst)
    (i_mem_ready || i_mem_done) |-> (lock_q != mem_pkg::LOCK_FREE));

endmodule

// ==== hw/instr_cache.sv ====
// Read-only direct-mapped cache; CACHE_LINES must be a power of two of at least 2, never snooped by data writes
module instr_cache #(
  parameter int CACHE_LINES = 8
) (
  input  logic                          i_clock,
  input  logic                          i_rst,
  // Wishbone classic fetch port
  input  logic                          i_ib_cyc,
  input  logic                          i_ib_stb,
  input  logic [mem_pkg::ADDR_BITS-1:0] i_ib_adr,
  output logic [mem_pkg::WORD_BITS-1:0] o_ib_dat,
  output logic                          o_ib_ack,
  // Line fill towards the arbiter
  output logic [mem_pkg::ADDR_BITS-1:0] o_fill_address,
  output logic                          o_fill_read,
  input  logic [mem_pkg::LINE_BITS-1:0] i_fill_rdata,
  input  logic                          i_fill_ready
);

  localparam int IDX_BITS  = $clog2(CACHE_LINES);
  localparam int TAG_BITS  = mem_pkg::ADDR_BITS - mem_pkg::OFFSET_BITS - IDX_BITS;
  localparam int WSEL_BITS = mem_pkg::OFFSET_BITS - 2;

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    FILL,
    RESPOND
  } state_e;

  state_e                        state_q;
  logic [mem_pkg::LINE_BITS-1:0] line_q [CACHE_LINES];
  logic [TAG_BITS-1:0]           tag_q [CACHE_LINES];
  logic [CACHE_LINES-1:0]        valid_q;

  logic [IDX_BITS-1:0]  idx;
  logic [TAG_BITS-1:0]  tag;
  logic [WSEL_BITS-1:0] word;
  logic                 hit;

  // Master keeps the address steady until ack
  assign idx  = i_ib_adr[mem_pkg::OFFSET_BITS +: IDX_BITS];
  assign tag  = i_ib_adr[mem_pkg::ADDR_BITS-1 -: TAG_BITS];
  assign word = i_ib_adr[mem_pkg::OFFSET_BITS-1:2];
  assign hit  = valid_q[idx] && (tag_q[idx] == tag);

  assign o_ib_dat = line_q[idx][word*mem_pkg::WORD_BITS +: mem_pkg::WORD_BITS];
  assign o_ib_ack = (state_q == LOOKUP && hit) || (state_q == RESPOND);

  assign o_fill_read    = (state_q == FILL);
  assign o_fill_address = {i_ib_adr[mem_pkg::ADDR_BITS-1:mem_pkg::OFFSET_BITS],
                           {mem_pkg::OFFSET_BITS{1'b0}}};

  always_ff @(posedge i_clock) begin
    if (i_rst) begin
      state_q <= IDLE;
      valid_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (i_ib_cyc && i_ib_stb) begin
            state_q <= LOOKUP;
          end
        end
        LOOKUP: begin
          state_q <= hit ? IDLE : FILL;
        end
        FILL: begin
          if (i_fill_ready) begin
            valid_q[idx] <= 1'b1;
            state_q      <= RESPOND;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // Line install
  always_ff @(posedge i_clock) begin
    if (state_q == FILL && i_fill_ready) begin
      line_q[idx] <= i_fill_rdata;
      tag_q[idx]  <= tag;
    end
  end

endmodule

// ==== hw/data_cache.sv ====
// Write-through, write-allocate direct-mapped cache; CACHE_LINES a power of two of at least 2, no coherence
module data_cache #(
  parameter int CACHE_LINES = 8
) (
  input  logic                          i_clock,
  input  logic                          i_rst,
  // Wishbone classic data port
  input  logic                          i_db_cyc,
  input  logic                          i_db_stb,
  input  logic                          i_db_we,
  input  logic [mem_pkg::ADDR_BITS-1:0] i_db_adr,
  input  logic [3:0]                    i_db_sel,
  input  logic [mem_pkg::WORD_BITS-1:0] i_db_dat,
  output logic [mem_pkg::WORD_BITS-1:0] o_db_dat,
  output logic                          o_db_ack,
  // Line transfers towards the arbiter
  output logic [mem_pkg::ADDR_BITS-1:0] o_line_address,
  output logic                          o_line_read,
  output logic                          o_line_write,
  output logic [mem_pkg::LINE_BITS-1:0] o_line_wdata,
  input  logic [mem_pkg::LINE_BITS-1:0] i_line_rdata,
  input  logic                          i_line_ready,
  input  logic                          i_line_done
);

  localparam int IDX_BITS  = $clog2(CACHE_LINES);
  localparam int TAG_BITS  = mem_pkg::ADDR_BITS - mem_pkg::OFFSET_BITS - IDX_BITS;
  localparam int WSEL_BITS = mem_pkg::OFFSET_BITS - 2;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    FILL,
    WRITE_BACK,
    RESPOND
  } state_e;

  state_e                        state_q;
  logic [mem_pkg::LINE_BITS-1:0] line_q [CACHE_LINES];
  logic [TAG_BITS-1:0]           tag_q [CACHE_LINES];
  logic [CACHE_LINES-1:0]        valid_q;

  logic [IDX_BITS-1:0]  idx;
  logic [TAG_BITS-1:0]  tag;
  logic [WSEL_BITS-1:0] word;
  logic                 hit;

  // Selected bytes of one word replaced inside a line
  function automatic logic [mem_pkg::LINE_BITS-1:0] merge_bytes(
    input logic [mem_pkg::LINE_BITS-1:0] line,
    input logic [WSEL_BITS-1:0]          sel_word,
    input logic [3:0]                    sel,
    input logic [mem_pkg::WORD_BITS-1:0] dat
  );
    logic [mem_pkg::LINE_BITS-1:0] merged;
    merged = line;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        merged[sel_word*mem_pkg::WORD_BITS + b*8 +: 8] = dat[b*8 +: 8];
      end
    end
    return merged;
  endfunction

  assign idx  = i_db_adr[mem_pkg::OFFSET_BITS +: IDX_BITS];
  assign tag  = i_db_adr[mem_pkg::ADDR_BITS-1 -: TAG_BITS];
  assign word = i_db_adr[mem_pkg::OFFSET_BITS-1:2];
  assign hit  = valid_q[idx] && (tag_q[idx] == tag);

  assign o_db_dat = line_q[idx][word*mem_pkg::WORD_BITS +: mem_pkg::WORD_BITS];
  // Read hits ack from LOOKUP, everything else from RESPOND
  assign o_db_ack = (state_q == LOOKUP && hit && !i_db_we) || (state_q == RESPOND);

  assign o_line_address = {i_db_adr[mem_pkg::ADDR_BITS-1:mem_pkg::OFFSET_BITS],
                           {mem_pkg::OFFSET_BITS{1'b0}}};
  assign o_line_read    = (state_q == FILL);
  assign o_line_write   = (state_q == WRITE_BACK);
  assign o_line_wdata   = line_q[idx];

  always_ff @(posedge i_clock) begin
    if (i_rst) begin
      state_q <= IDLE;
      valid_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (i_db_cyc && i_db_stb) begin
            state_q <= LOOKUP;
          end
        end
        LOOKUP: begin
          if (!hit) begin
            state_q <= FILL;
          end else if (i_db_we) begin
            state_q <= WRITE_BACK;
          end else begin
            state_q <= IDLE;
          end
        end
        FILL: begin
          if (i_line_ready) begin
            valid_q[idx] <= 1'b1;
            state_q      <= i_db_we ? WRITE_BACK : RESPOND;
          end
        end
        WRITE_BACK: begin
          if (i_line_done) begin
            state_q <= RESPOND;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // Store merges on a hit, or into the freshly filled line
  always_ff @(posedge i_clock) begin
    if (state_q == LOOKUP && hit && i_db_we) begin
      line_q[idx] <= merge_bytes(line_q[idx], word, i_db_sel, i_db_dat);
    end else if (state_q == FILL && i_line_ready) begin
      line_q[idx] <= i_db_we ? merge_bytes(i_line_rdata, word, i_db_sel, i_db_dat)
                             : i_line_rdata;
      tag_q[idx]  <= tag;
    end
  end

  // Line being written back must be the one the store targets
  a_wb_line_valid: assert property (@(posedge i_clock) disable iff (i_rst)
    (state_q == WRITE_BACK && $past(state_q) != WRITE_BACK)
      |-> (valid_q[idx] && tag_q[idx] == tag));

endmodule

// ==== hw/line_memory.sv ====
// MEM_LINES a power of two so addresses wrap on the low index bits; MEM_LATENCY at least 1; read and write exclusive
module line_memory #(
  parameter int MEM_LINES   = 64,
  parameter int MEM_LATENCY = 4
) (
  input  logic                          i_clock,
  input  logic                          i_rst,
  input  logic [mem_pkg::ADDR_BITS-1:0] i_mem_address,
  input  logic                          i_mem_read,
  input  logic                          i_mem_write,
  input  logic [mem_pkg::LINE_BITS-1:0] i_mem_wdata,
  output logic [mem_pkg::LINE_BITS-1:0] o_mem_rdata,
  output logic                          o_mem_ready,
  output logic                          o_mem_done
);

  localparam int IDX_BITS = $clog2(MEM_LINES);
  localparam int CNT_BITS = $clog2(MEM_LATENCY + 1);

  logic [mem_pkg::LINE_BITS-1:0] mem_q [MEM_LINES];
  logic [CNT_BITS-1:0]           cnt_q;
  logic [IDX_BITS-1:0]           idx;
  logic                          fire;

  assign idx = i_mem_address[mem_pkg::OFFSET_BITS +: IDX_BITS];

  // Last wait cycle of an access still pending, not in its own response cycle
  assign fire = (i_mem_read || i_mem_write) && !(o_mem_ready || o_mem_done) &&
                (cnt_q == CNT_BITS'(MEM_LATENCY - 1));

  // Word w of the whole memory holds 0x1000_0000 + w
  initial begin
    for (int l = 0; l < MEM_LINES; l++) begin
      for (int w = 0; w < mem_pkg::WORDS_PER_LINE; w++) begin
        mem_q[l][w*mem_pkg::WORD_BITS +: mem_pkg::WORD_BITS] =
          32'h1000_0000 + l * mem_pkg::WORDS_PER_LINE + w;
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_rst) begin
      cnt_q       <= '0;
      o_mem_ready <= 1'b0;
      o_mem_done  <= 1'b0;
    end else begin
      o_mem_ready <= fire && i_mem_read;
      o_mem_done  <= fire && i_mem_write;
      if ((i_mem_read || i_mem_write) && !(o_mem_ready || o_mem_done) && !fire) begin
        cnt_q <= cnt_q + 1'b1;
      end else begin
        cnt_q <= '0;
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (fire) begin
      o_mem_rdata <= mem_q[idx];
    end
  end

  always @(posedge i_clock) begin
    if (fire && i_mem_write) begin
      mem_q[idx] <= i_mem_wdata;
    end
  end

endmodule

// ==== hw/cache_subsystem_top.sv ====
// Caches are not coherent with each other; parameter limits are those of the caches and the line memory
module cache_subsystem_top #(
  parameter int CACHE_LINES = 8,
  parameter int MEM_LINES   = 64,
  parameter int MEM_LATENCY = 4
) (
  input  logic                          i_clock,
  input  logic                          i_rst,
  // Fetch port
  input  logic                          i_ib_cyc,
  input  logic                          i_ib_stb,
  input  logic [mem_pkg::ADDR_BITS-1:0] i_ib_adr,
  output logic [mem_pkg::WORD_BITS-1:0] o_ib_dat,
  output logic                          o_ib_ack,
  // Data port
  input  logic                          i_db_cyc,
  input  logic                          i_db_stb,
  input  logic                          i_db_we,
  input  logic [mem_pkg::ADDR_BITS-1:0] i_db_adr,
  input  logic [3:0]                    i_db_sel,
  input  logic [mem_pkg::WORD_BITS-1:0] i_db_dat,
  output logic [mem_pkg::WORD_BITS-1:0] o_db_dat,
  output logic                          o_db_ack
);

  logic [mem_pkg::ADDR_BITS-1:0] ic_address;
  logic                          ic_read;
  logic [mem_pkg::LINE_BITS-1:0] ic_rdata;
  logic                          ic_ready;

  logic [mem_pkg::ADDR_BITS-1:0] dc_address;
  logic                          dc_read;
  logic                          dc_write;
  logic [mem_pkg::LINE_BITS-1:0] dc_wdata;
  logic [mem_pkg::LINE_BITS-1:0] dc_rdata;
  logic                          dc_ready;
  logic                          dc_done;

  logic [mem_pkg::ADDR_BITS-1:0] mem_address;
  logic                          mem_read;
  logic                          mem_write;
  logic [mem_pkg::LINE_BITS-1:0] mem_wdata;
  logic [mem_pkg::LINE_BITS-1:0] mem_rdata;
  logic                          mem_ready;
  logic                          mem_done;

  instr_cache #(
    .CACHE_LINES(CACHE_LINES)
  ) instr_cache_i (
    .i_clock       (i_clock),
    .i_rst         (i_rst),
    .i_ib_cyc      (i_ib_cyc),
    .i_ib_stb      (i_ib_stb),
    .i_ib_adr      (i_ib_adr),
    .o_ib_dat      (o_ib_dat),
    .o_ib_ack      (o_ib_ack),
    .o_fill_address(ic_address),
    .o_fill_read   (ic_read),
    .i_fill_rdata  (ic_rdata),
    .i_fill_ready  (ic_ready)
  );

  data_cache #(
    .CACHE_LINES(CACHE_LINES)
  ) data_cache_i (
    .i_clock       (i_clock),
    .i_rst         (i_rst),
    .i_db_cyc      (i_db_cyc),
    .i_db_stb      (i_db_stb),
    .i_db_we       (i_db_we),
    .i_db_adr      (i_db_adr),
    .i_db_sel      (i_db_sel),
    .i_db_dat      (i_db_dat),
    .o_db_dat      (o_db_dat),
    .o_db_ack      (o_db_ack),
    .o_line_address(dc_address),
    .o_line_read   (dc_read),
    .o_line_write  (dc_write),
    .o_line_wdata  (dc_wdata),
    .i_line_rdata  (dc_rdata),
    .i_line_ready  (dc_ready),
    .i_line_done   (dc_done)
  );

  line_arbiter line_arbiter_i (
    .i_clock      (i_clock),
    .i_rst        (i_rst),
    .i_ic_address (ic_address),
    .i_ic_read    (ic_read),
    .o_ic_rdata   (ic_rdata),
    .o_ic_ready   (ic_ready),
    .i_dc_address (dc_address),
    .i_dc_read    (dc_read),
    .i_dc_write   (dc_write),
    .i_dc_wdata   (dc_wdata),
    .o_dc_rdata   (dc_rdata),
    .o_dc_ready   (dc_ready),
    .o_dc_done    (dc_done),
    .o_mem_address(mem_address),
    .o_mem_read   (mem_read),
    .o_mem_write  (mem_write),
    .o_mem_wdata  (mem_wdata),
    .i_mem_rdata  (mem_rdata),
    .i_mem_ready  (mem_ready),
    .i_mem_done   (mem_done)
  );

  line_memory #(
    .MEM_LINES  (MEM_LINES),
    .MEM_LATENCY(MEM_LATENCY)
  ) line_memory_i (
    .i_clock      (i_clock),
    .i_rst        (i_rst),
    .i_mem_address(mem_address),
    .i_mem_read   (mem_read),
    .i_mem_write  (mem_write),
    .i_mem_wdata  (mem_wdata),
    .o_mem_rdata  (mem_rdata),
    .o_mem_ready  (mem_ready),
    .o_mem_done   (mem_done)
  );

endmodule

// ==== verif/cache_subsystem_tb.sv ====
// Needs MEM_LATENCY of at least 1 and the power-on memory pattern; fetched lines stay unwritten
module cache_subsystem_tb;

  localparam int CACHE_LINES     = 8;
  localparam int MEM_LINES       = 64;
  localparam int MEM_LATENCY     = 4;
  localparam int MEM_WORDS       = MEM_LINES * mem_pkg::WORDS_PER_LINE;
  localparam int RANDOM_ACCESSES = 40;
  // Directed accesses of the fetch, read/write and concurrent tests plus the random mix
  localparam int ACCESSES        = 3 + 4 + 6 + RANDOM_ACCESSES;
  localparam int WATCHDOG_CYCLES = ACCESSES * (2 * MEM_LATENCY + 10) + 100;

  logic        clock;
  logic        rst;
  logic        ib_cyc;
  logic        ib_stb;
  logic [31:0] ib_adr;
  logic [31:0] ib_dat;
  logic        ib_ack;
  logic        db_cyc;
  logic        db_stb;
  logic        db_we;
  logic [31:0] db_adr;
  logic [3:0]  db_sel;
  logic [31:0] db_wdat;
  logic [31:0] db_rdat;
  logic        db_ack;

  // Expected contents of the line memory, one entry per word
  logic [31:0] ref_mem [MEM_WORDS];
  int          checks;
  int          errors;

  cache_subsystem_top #(
    .CACHE_LINES(CACHE_LINES),
    .MEM_LINES  (MEM_LINES),
    .MEM_LATENCY(MEM_LATENCY)
  ) cache_subsystem_top_i (
    .i_clock (clock),
    .i_rst   (rst),
    .i_ib_cyc(ib_cyc),
    .i_ib_stb(ib_stb),
    .i_ib_adr(ib_adr),
    .o_ib_dat(ib_dat),
    .o_ib_ack(ib_ack),
    .i_db_cyc(db_cyc),
    .i_db_stb(db_stb),
    .i_db_we (db_we),
    .i_db_adr(db_adr),
    .i_db_sel(db_sel),
    .i_db_dat(db_wdat),
    .o_db_dat(db_rdat),
    .o_db_ack(db_ack)
  );

  always #2 clock = ~clock;

  // Memory wraps so only the low word address bits count
  function automatic int word_index(input logic [31:0] adr);
    return int'((adr >> 2) % MEM_WORDS);
  endfunction

  task automatic store_reference(input logic [31:0] adr, input logic [3:0] sel,
                                 input logic [31:0] dat);
    int w;
    w = word_index(adr);
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        ref_mem[w][b*8 +: 8] = dat[b*8 +: 8];
      end
    end
  endtask

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic verify_latency(input string what, input int cycles, input bit hit);
    checks++;
    if (hit) begin
      assert (cycles == 1) else begin
        errors++;
        $display("error at %0t: %s hit latency = %0d cycles, expected 1",
                 $time, what, cycles);
      end
    end else begin
      assert (cycles >= MEM_LATENCY + 3) else begin
        errors++;
        $display("error at %0t: %s miss latency = %0d cycles, expected at least %0d",
                 $time, what, cycles, MEM_LATENCY + 3);
      end
    end
  endtask

  // Starts 1 unit after a rising edge and ends at the same phase
  task automatic fetch(input logic [31:0] adr, output int cycles);
    logic [31:0] got;
    cycles = 0;
    ib_cyc = 1'b1;
    ib_stb = 1'b1;
    ib_adr = adr;
    @(negedge clock);
    while (!ib_ack) begin
      cycles++;
      @(negedge clock);
    end
    got = ib_dat;
    @(posedge clock);
    #1;
    ib_cyc = 1'b0;
    ib_stb = 1'b0;
    compare_word("o_ib_dat", got, ref_mem[word_index(adr)]);
  endtask

  task automatic dat_access(input logic we, input logic [31:0] adr, input logic [3:0] sel,
                            input logic [31:0] dat, output int cycles);
    logic [31:0] got;
    cycles  = 0;
    db_cyc  = 1'b1;
    db_stb  = 1'b1;
    db_we   = we;
    db_adr  = adr;
    db_sel  = sel;
    db_wdat = dat;
    if (we) begin
      store_reference(adr, sel, dat);
    end
    @(negedge clock);
    while (!db_ack) begin
      cycles++;
      @(negedge clock);
    end
    got = db_rdat;
    @(posedge clock);
    #1;
    db_cyc = 1'b0;
    db_stb = 1'b0;
    db_we  = 1'b0;
    if (!we) begin
      compare_word("o_db_dat", got, ref_mem[word_index(adr)]);
    end
  endtask

  task automatic idle_acks_low();
    repeat (10) begin
      @(negedge clock);
      compare_word("o_ib_ack", 32'(ib_ack), 32'h0);
      compare_word("o_db_ack", 32'(db_ack), 32'h0);
    end
    @(posedge clock);
    #1;
  endtask

  task automatic fetch_line_hits();
    int cycles;
    fetch(32'h0000_0040, cycles);
    verify_latency("fetch", cycles, 1'b0);
    fetch(32'h0000_0040, cycles);
    verify_latency("fetch", cycles, 1'b1);
    // Neighbouring word of the same line
    fetch(32'h0000_0044, cycles);
    verify_latency("fetch", cycles, 1'b1);
  endtask

  task automatic data_write_through();
    int cycles;
    dat_access(1'b0, 32'h0000_0108, 4'hf, 32'h0, cycles);
    dat_access(1'b1, 32'h0000_0108, 4'b0010, 32'hAABB_CCDD, cycles);
    dat_access(1'b0, 32'h0000_0108, 4'hf, 32'h0, cycles);
    verify_latency("data read", cycles, 1'b1);
    // First fetch of this line comes from memory after the write-through
    fetch(32'h0000_0108, cycles);
  endtask

  task automatic concurrent_ports();
    int ic_cycles;
    int dc_cycles;
    fork
      fetch(32'h0000_0184, ic_cycles);
      dat_access(1'b0, 32'h0000_0064, 4'hf, 32'h0, dc_cycles);
    join
    // Write miss on index 0 evicts the line of 0x108
    fork
      fetch(32'h0000_0188, ic_cycles);
      dat_access(1'b1, 32'h0000_0208, 4'b1001, 32'h1234_5678, dc_cycles);
    join
    dat_access(1'b0, 32'h0000_0108, 4'hf, 32'h0, dc_cycles);
    dat_access(1'b0, 32'h0000_0208, 4'hf, 32'h0, dc_cycles);
  endtask

  task automatic random_data_mix();
    int          line;
    int          cycles;
    logic [31:0] adr;
    logic        we;
    logic [3:0]  sel;
    logic [31:0] dat;
    for (int n = 0; n < RANDOM_ACCESSES; n++) begin
      // Three lines per cache index away from the fetched lines
      line = 32 + 8 * int'($urandom % 3) + int'($urandom % CACHE_LINES);
      adr  = 32'(line * 32 + int'($urandom % 8) * 4);
      we   = 1'($urandom % 2);
      sel  = 4'($urandom % 16);
      dat  = $urandom;
      dat_access(we, adr, sel, dat, cycles);
    end
  endtask

  initial begin
    clock   = 1'b0;
    rst     = 1'b1;
    ib_cyc  = 1'b0;
    ib_stb  = 1'b0;
    ib_adr  = '0;
    db_cyc  = 1'b0;
    db_stb  = 1'b0;
    db_we   = 1'b0;
    db_adr  = '0;
    db_sel  = '0;
    db_wdat = '0;
    checks  = 0;
    errors  = 0;
    void'($urandom(25));
    for (int w = 0; w < MEM_WORDS; w++) begin
      ref_mem[w] = 32'h1000_0000 + 32'(w);
    end
    repeat (8) @(posedge clock);
    #1;
    rst = 1'b0;
    idle_acks_low();
    fetch_line_hits();
    data_write_through();
    concurrent_ports();
    random_data_mix();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * 4);
    $display("watchdog expired after %0d cycles, a bus access never completed",
             WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== list.f ====
hw/mem_pkg.sv
hw/line_arbiter.sv
hw/instr_cache.sv
hw/data_cache.sv
hw/line_memory.sv
hw/cache_subsystem_top.sv
verif/cache_subsystem_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = cache_subsystem_tb
FILE_LIST = list.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } /^RESULT: PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)
